/* verilog/cache_pkg.sv */
package cache_pkg;

    // fixed widths of the processor and memory ports
    localparam int DATA_WIDTH   = 32;
    localparam int ADDRESS_BITS = 32;
    localparam int BYTE_LANES   = DATA_WIDTH / 8;

    typedef logic [DATA_WIDTH-1:0]   word_t;
    typedef logic [ADDRESS_BITS-1:0] addr_t;
    typedef logic [BYTE_LANES-1:0]   byte_en_t;
    typedef logic [3:0]              msg_t;

    // memory port message codes
    localparam msg_t NO_REQ   = 4'd0;
    localparam msg_t R_REQ    = 4'd1;
    localparam msg_t WB_REQ   = 4'd2;
    localparam msg_t FLUSH    = 4'd3;
    // memory done with the line for R_REQ
    localparam msg_t MEM_RESP = 4'd4;

    typedef enum logic [3:0] {
        RESET,
        IDLE,
        CACHE_ACCESS,
        WRITE_BACK,
        WB_WAIT,
        READ_STATE,
        WAIT,
        UPDATE,
        SRV_FLUSH_REQ,
        WAIT_FLUSH_REQ
    } ctrl_state_t;

endpackage

/* verilog/cache_array_if.sv */
`timescale 1ns/100ps

interface cache_array_if
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 4
) ();

    localparam int TAG_BITS = ADDRESS_BITS - 2 - INDEX_BITS;

    // requests from the controller
    logic                  lookup;
    logic                  write_en;
    logic                  invalidate;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    word_t                 wdata;
    logic                  dirty_in;

    // registered results of the last lookup
    word_t                 rdata;
    logic [TAG_BITS-1:0]   tag_out;
    logic                  hit;
    logic                  dirty_out;

    modport controller (
        output lookup, write_en, invalidate, index, tag, wdata, dirty_in,
        input  rdata, tag_out, hit, dirty_out
    );

    modport storage (
        input  lookup, write_en, invalidate, index, tag, wdata, dirty_in,
        output rdata, tag_out, hit, dirty_out
    );

endinterface

/* verilog/cache_arrays.sv */
`timescale 1ns/100ps

module cache_arrays
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic           clock,
    input  logic           arst_n,
    cache_array_if.storage bus
);

    localparam int TAG_BITS = ADDRESS_BITS - 2 - INDEX_BITS;
    localparam int DEPTH    = 1 << INDEX_BITS;

    logic [DEPTH-1:0]    valid_bits;
    logic [DEPTH-1:0]    dirty_bits;
    logic [TAG_BITS-1:0] tag_mem [DEPTH];
    word_t               data_mem [DEPTH];

    logic                entry_valid;
    logic                tag_match;

    assign entry_valid = valid_bits[bus.index];
    assign tag_match   = (tag_mem[bus.index] == bus.tag);

    // valid bits also cleared directly by reset
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            valid_bits <= '0;
        end else if (bus.invalidate) begin
            valid_bits[bus.index] <= 1'b0;
        end else if (bus.write_en) begin
            valid_bits[bus.index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (bus.write_en) begin
            tag_mem[bus.index]    <= bus.tag;
            data_mem[bus.index]   <= bus.wdata;
            dirty_bits[bus.index] <= bus.dirty_in;
        end
    end

    // hit and dirty flags of the looked-up entry
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            bus.hit       <= 1'b0;
            bus.dirty_out <= 1'b0;
        end else if (bus.lookup) begin
            bus.hit       <= entry_valid & tag_match;
            bus.dirty_out <= entry_valid & dirty_bits[bus.index];
        end
    end

    // stored line and tag kept for a possible write-back
    always_ff @(posedge clock) begin
        if (bus.lookup) begin
            bus.rdata   <= data_mem[bus.index];
            bus.tag_out <= tag_mem[bus.index];
        end
    end

endmodule

/* verilog/cache_controller.sv */
`timescale 1ns/100ps

module cache_controller
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic              clock,
    input  logic              arst_n,
    input  logic              read,
    input  logic              write,
    input  logic              flush,
    input  addr_t             address,
    input  word_t             data_in,
    input  byte_en_t          byte_en,
    output logic              ready,
    output logic              valid,
    output word_t             data_out,
    output msg_t              cache2mem_msg,
    output addr_t             cache2mem_address,
    output word_t             cache2mem_data,
    input  msg_t              mem2cache_msg,
    input  word_t             mem2cache_data,
    cache_array_if.controller bus
);

    localparam int TAG_BITS = ADDRESS_BITS - 2 - INDEX_BITS;

    ctrl_state_t           state;
    logic [INDEX_BITS-1:0] reset_counter;

    // accepted request
    logic                  req_read;
    logic                  req_write;
    logic                  req_flush;
    addr_t                 req_address;
    word_t                 req_data;
    byte_en_t              req_byte_en;

    // entry found at the request index
    logic                  victim_dirty;
    logic [TAG_BITS-1:0]   victim_tag;
    word_t                 victim_data;
    word_t                 mem_word;

    logic                  one_request;
    logic                  accept;
    logic                  mem_resp;
    logic                  read_hit;
    logic [INDEX_BITS-1:0] address_index;
    logic [TAG_BITS-1:0]   address_tag;
    logic [INDEX_BITS-1:0] req_index;
    logic [TAG_BITS-1:0]   req_tag;
    addr_t                 req_line_address;
    word_t                 merge_base;

    assign address_index    = address[2 +: INDEX_BITS];
    assign address_tag      = address[ADDRESS_BITS-1 -: TAG_BITS];
    assign req_index        = req_address[2 +: INDEX_BITS];
    assign req_tag          = req_address[ADDRESS_BITS-1 -: TAG_BITS];
    assign req_line_address = {req_address[ADDRESS_BITS-1:2], 2'b00};

    assign one_request = (read & ~write & ~flush) | (~read & write & ~flush) |
                         (~read & ~write & flush);
    assign mem_resp    = (mem2cache_msg == MEM_RESP);

    // a read hit frees the port for the next request
    assign read_hit = (state == CACHE_ACCESS) & req_read & bus.hit;
    assign ready    = (state == IDLE) | read_hit;
    assign accept   = ready & one_request;

    assign valid    = read_hit | ((state == UPDATE) & req_read);
    assign data_out = !valid ? '0 : (state == UPDATE) ? mem_word : bus.rdata;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state         <= RESET;
            reset_counter <= '0;
            req_read      <= 1'b0;
            req_write     <= 1'b0;
            req_flush     <= 1'b0;
            victim_dirty  <= 1'b0;
            cache2mem_msg <= NO_REQ;
        end else begin
            if (accept) begin
                req_read  <= read;
                req_write <= write;
                req_flush <= flush;
            end
            case (state)
                RESET: begin
                    reset_counter <= reset_counter + 1'b1;
                    if (&reset_counter) begin
                        state <= IDLE;
                    end
                end
                IDLE: begin
                    if (accept) begin
                        state <= CACHE_ACCESS;
                    end
                end
                CACHE_ACCESS: begin
                    victim_dirty <= bus.dirty_out;
                    if (req_flush) begin
                        state <= bus.hit ? SRV_FLUSH_REQ : IDLE;
                    end else if (bus.hit) begin
                        state <= accept ? CACHE_ACCESS : IDLE;
                    end else begin
                        state <= bus.dirty_out ? WRITE_BACK : READ_STATE;
                    end
                end
                WRITE_BACK: begin
                    cache2mem_msg <= WB_REQ;
                    state         <= WB_WAIT;
                end
                WB_WAIT: begin
                    if (mem_resp) begin
                        cache2mem_msg <= NO_REQ;
                        state         <= READ_STATE;
                    end
                end
                READ_STATE: begin
                    cache2mem_msg <= R_REQ;
                    state         <= WAIT;
                end
                WAIT: begin
                    if (mem_resp) begin
                        cache2mem_msg <= NO_REQ;
                        state         <= UPDATE;
                    end
                end
                UPDATE: begin
                    state <= IDLE;
                end
                SRV_FLUSH_REQ: begin
                    // clean lines are dropped here without a message
                    if (victim_dirty) begin
                        cache2mem_msg <= FLUSH;
                        state         <= WAIT_FLUSH_REQ;
                    end else begin
                        state <= IDLE;
                    end
                end
                WAIT_FLUSH_REQ: begin
                    if (mem_resp) begin
                        cache2mem_msg <= NO_REQ;
                        state         <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_address <= address;
            req_data    <= data_in;
            req_byte_en <= byte_en;
        end
        if (state == CACHE_ACCESS) begin
            victim_tag  <= bus.tag_out;
            victim_data <= bus.rdata;
        end
        if ((state == WAIT) && mem_resp) begin
            mem_word <= mem2cache_data;
        end
        // address and data held with the message until MEM_RESP
        if (state == WRITE_BACK) begin
            cache2mem_address <= {victim_tag, req_index, 2'b00};
            cache2mem_data    <= victim_data;
        end else if (state == READ_STATE) begin
            cache2mem_address <= req_line_address;
            cache2mem_data    <= '0;
        end else if ((state == SRV_FLUSH_REQ) && victim_dirty) begin
            cache2mem_address <= req_line_address;
            cache2mem_data    <= victim_data;
        end
    end

    assign bus.lookup     = accept;
    assign bus.write_en   = ((state == CACHE_ACCESS) & req_write & bus.hit) |
                            (state == UPDATE);
    assign bus.invalidate = (state == RESET) |
                            ((state == SRV_FLUSH_REQ) & ~victim_dirty) |
                            ((state == WAIT_FLUSH_REQ) & mem_resp);
    assign bus.dirty_in   = req_write;

    assign bus.index = (state == RESET) ? reset_counter :
                       accept ? address_index : req_index;
    assign bus.tag   = accept ? address_tag : req_tag;

    // write data merged over the stored or fetched word
    assign merge_base = (state == UPDATE) ? mem_word : bus.rdata;

    always_comb begin
        bus.wdata = merge_base;
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (req_write && req_byte_en[i]) begin
                bus.wdata[8*i +: 8] = req_data[8*i +: 8];
            end
        end
    end

endmodule

/* verilog/l1_cache.sv */
`timescale 1ns/100ps

module l1_cache
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input  logic     clock,
    input  logic     arst_n,
    input  logic     read,
    input  logic     write,
    input  logic     flush,
    input  addr_t    address,
    input  word_t    data_in,
    input  byte_en_t byte_en,
    input  msg_t     mem2cache_msg,
    input  word_t    mem2cache_data,
    output logic     ready,
    output logic     valid,
    output word_t    data_out,
    output msg_t     cache2mem_msg,
    output addr_t    cache2mem_address,
    output word_t    cache2mem_data
);

    cache_array_if #(
        .INDEX_BITS(INDEX_BITS)
    ) array_bus ();

    cache_controller #(
        .INDEX_BITS(INDEX_BITS)
    ) controller_inst (
        .clock             (clock),
        .arst_n            (arst_n),
        .read              (read),
        .write             (write),
        .flush             (flush),
        .address           (address),
        .data_in           (data_in),
        .byte_en           (byte_en),
        .ready             (ready),
        .valid             (valid),
        .data_out          (data_out),
        .cache2mem_msg     (cache2mem_msg),
        .cache2mem_address (cache2mem_address),
        .cache2mem_data    (cache2mem_data),
        .mem2cache_msg     (mem2cache_msg),
        .mem2cache_data    (mem2cache_data),
        .bus               (array_bus.controller)
    );

    // tag, data and status storage
    cache_arrays #(
        .INDEX_BITS(INDEX_BITS)
    ) arrays_inst (
        .clock  (clock),
        .arst_n (arst_n),
        .bus    (array_bus.storage)
    );

endmodule

/* tb/l1_cache_checker.sv */
`timescale 1ns/100ps

module l1_cache_checker
    import cache_pkg::*;
#(
    parameter int INDEX_BITS = 4
) (
    input logic  clock,
    input logic  arst_n,
    input logic  ready,
    input logic  valid,
    input msg_t  cache2mem_msg,
    input addr_t cache2mem_address,
    input word_t cache2mem_data,
    input msg_t  mem2cache_msg
);

    localparam int SWEEP_CYCLES = 1 << INDEX_BITS;

    // cycles since reset release up to the sweep length
    int sweep_count;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            sweep_count <= 0;
        end else if (sweep_count < SWEEP_CYCLES) begin
            sweep_count <= sweep_count + 1;
        end
    end

    assert property (@(posedge clock) disable iff (!arst_n)
        ((cache2mem_msg != NO_REQ) && (mem2cache_msg != MEM_RESP)) |=>
            ($stable(cache2mem_msg) && $stable(cache2mem_address) && $stable(cache2mem_data)))
        else $error("memory request changed before MEM_RESP");

    assert property (@(posedge clock) disable iff (!arst_n)
        ((cache2mem_msg != NO_REQ) && (mem2cache_msg == MEM_RESP)) |=> (cache2mem_msg == NO_REQ))
        else $error("memory request not released after MEM_RESP");

    // reset and the valid sweep keep the processor side quiet
    assert property (@(posedge clock)
        (sweep_count < SWEEP_CYCLES) |-> (!ready && !valid && (cache2mem_msg == NO_REQ)))
        else $error("ready, valid or a message active during reset sweep");

    assert property (@(posedge clock) disable iff (!arst_n)
        !(valid && (cache2mem_msg != NO_REQ)))
        else $error("valid raised while a memory request is active");

endmodule

/* tb/l1_cache_tb.sv */
`timescale 1ns/100ps

module l1_cache_tb
    import cache_pkg::*;
();

    localparam int INDEX_BITS     = 4;
    localparam int TAG_BITS       = ADDRESS_BITS - 2 - INDEX_BITS;
    localparam int DEPTH          = 1 << INDEX_BITS;
    localparam int NUM_OPS        = 215;
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + DEPTH;
    localparam logic [31:0] SEED  = 32'd77650;
    localparam logic [1:0] OP_READ  = 2'd0;
    localparam logic [1:0] OP_WRITE = 2'd1;
    localparam logic [1:0] OP_FLUSH = 2'd2;

    logic     clock;
    logic     arst_n;
    logic     read;
    logic     write;
    logic     flush;
    addr_t    address;
    word_t    data_in;
    byte_en_t byte_en;
    msg_t     mem2cache_msg;
    word_t    mem2cache_data;
    logic     ready;
    logic     valid;
    word_t    data_out;
    msg_t     cache2mem_msg;
    addr_t    cache2mem_address;
    word_t    cache2mem_data;

    // processor view of memory and the backing memory
    word_t shadow_mem [addr_t];
    word_t main_mem [addr_t];
    logic                m_valid [DEPTH];
    logic                m_dirty [DEPTH];
    logic [TAG_BITS-1:0] m_tag [DEPTH];

    // outstanding reads and memory messages in the order they are due
    word_t read_q [$];
    logic  hit_q [$];
    int    accept_q [$];
    msg_t  msg_q [$];
    addr_t msg_addr_q [$];
    word_t msg_data_q [$];

    int          cycles = 0;
    int          check_count = 0;
    int          error_count = 0;
    int          test_errors = 0;
    int          test_num = 1;
    int          accept_cycle;
    int          exp_cycle;
    word_t       exp_data;
    logic [31:0] drv_seed;
    logic [31:0] resp_seed;

    l1_cache #(.INDEX_BITS(INDEX_BITS)) l1_cache_inst (.*);

    bind l1_cache l1_cache_checker #(.INDEX_BITS(INDEX_BITS)) checker_inst (.*);

    always #10 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic word_t fill_word(input addr_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    function automatic word_t expected_word(input addr_t a);
        return shadow_mem.exists(a) ? shadow_mem[a] : fill_word(a);
    endfunction

    function automatic word_t main_word(input addr_t a);
        return main_mem.exists(a) ? main_mem[a] : fill_word(a);
    endfunction

    function automatic void apply_write(input addr_t a, input word_t data, input byte_en_t be);
        word_t w;
        w = expected_word(a);
        for (int i = 0; i < BYTE_LANES; i++) begin
            if (be[i]) begin
                w[8*i +: 8] = data[8*i +: 8];
            end
        end
        shadow_mem[a] = w;
    endfunction

    function automatic void expect_message(input msg_t msg, input addr_t a, input word_t data);
        msg_q.push_back(msg);
        msg_addr_q.push_back(a);
        msg_data_q.push_back(data);
    endfunction

    // model of one accepted request
    function automatic void predict(input logic [1:0] op, input addr_t a, input word_t data,
                                    input byte_en_t be);
        logic [INDEX_BITS-1:0] idx;
        logic                  hit;
        addr_t                 line;
        addr_t                 victim;
        idx    = a[2 +: INDEX_BITS];
        line   = {a[ADDRESS_BITS-1:2], 2'b00};
        hit    = m_valid[idx] && (m_tag[idx] == a[ADDRESS_BITS-1 -: TAG_BITS]);
        victim = {m_tag[idx], idx, 2'b00};
        if (op == OP_FLUSH) begin
            if (hit && m_dirty[idx]) begin
                expect_message(FLUSH, line, expected_word(line));
            end
            if (hit) begin
                m_valid[idx] = 1'b0;
            end
        end else begin
            if (!hit) begin
                if (m_valid[idx] && m_dirty[idx]) begin
                    expect_message(WB_REQ, victim, expected_word(victim));
                end
                expect_message(R_REQ, line, '0);
                m_valid[idx] = 1'b1;
                m_dirty[idx] = 1'b0;
                m_tag[idx]   = a[ADDRESS_BITS-1 -: TAG_BITS];
            end
            if (op == OP_WRITE) begin
                m_dirty[idx] = 1'b1;
                apply_write(line, data, be);
            end else begin
                read_q.push_back(expected_word(line));
                hit_q.push_back(hit);
                accept_q.push_back(cycles);
            end
        end
    endfunction

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string what);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s, got %h expected %h",
                     $time, what, actual, expected);
        end
    endtask

    task automatic do_request(input logic [1:0] op, input addr_t a, input word_t data,
                              input byte_en_t be);
        @(negedge clock);
        read    = (op == OP_READ);
        write   = (op == OP_WRITE);
        flush   = (op == OP_FLUSH);
        address = a;
        data_in = data;
        byte_en = be;
        do begin
            @(posedge clock);
        end while (!ready);
        accept_cycle = cycles;
        predict(op, a, data, be);
    endtask

    task automatic wait_idle();
        @(negedge clock);
        read  = 1'b0;
        write = 1'b0;
        flush = 1'b0;
        while ((read_q.size() != 0) || (msg_q.size() != 0) || !ready) begin
            @(posedge clock);
        end
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: FAILED", test_num, name);
        end
        test_num++;
        test_errors = error_count;
    endtask

    task automatic serve_message();
        int delay;
        if (msg_q.size() == 0) begin
            error_count++;
            $display("unexpected memory message %0d to address %h at %0t",
                     cache2mem_msg, cache2mem_address, $time);
        end else begin
            check(32'(cache2mem_msg), 32'(msg_q.pop_front()), "memory message code");
            check(cache2mem_address, msg_addr_q.pop_front(), "memory message address");
            exp_data = msg_data_q.pop_front();
            if (cache2mem_msg != R_REQ) begin
                check(cache2mem_data, exp_data, "write-back data");
            end
        end
        if (cache2mem_msg != R_REQ) begin
            main_mem[cache2mem_address] = cache2mem_data;
        end
        resp_seed = lcg_next(resp_seed);
        delay = int'(resp_seed[31:16]) % 6 + 1;
        repeat (delay - 1) @(negedge clock);
        mem2cache_data = (cache2mem_msg == R_REQ) ? main_word(cache2mem_address) : '0;
        mem2cache_msg  = MEM_RESP;
    endtask

    // memory side answering on the falling edge
    initial begin
        mem2cache_msg  = NO_REQ;
        mem2cache_data = '0;
        resp_seed      = lcg_next(SEED);
        forever begin
            @(negedge clock);
            if (mem2cache_msg == MEM_RESP) begin
                mem2cache_msg  = NO_REQ;
                mem2cache_data = '0;
            end else if (arst_n && (cache2mem_msg != NO_REQ)) begin
                serve_message();
            end
        end
    end

    always @(posedge clock) begin
        if (valid) begin
            if (read_q.size() == 0) begin
                error_count++;
                $display("valid raised with no read outstanding at %0t", $time);
            end else begin
                check(data_out, read_q.pop_front(), "read data");
                exp_cycle = accept_q.pop_front();
                if (hit_q.pop_front()) begin
                    check(cycles - exp_cycle, 32'd1, "read hit latency");
                end
            end
        end else if (arst_n) begin
            check(data_out, '0, "data_out while valid is low");
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        addr_t      burst [5];
        addr_t      rand_addr;
        logic [1:0] op;
        int         prev_cycle;
        burst    = '{32'h80, 32'h88, 32'h8C, 32'h80, 32'h88};
        clock    = 1'b0;
        arst_n   = 1'b0;
        read     = 1'b0;
        write    = 1'b0;
        flush    = 1'b0;
        address  = '0;
        data_in  = '0;
        byte_en  = '0;
        drv_seed = SEED;
        for (int i = 0; i < DEPTH; i++) begin
            m_valid[i] = 1'b0;
            m_dirty[i] = 1'b0;
            m_tag[i]   = '0;
        end
        repeat (2) @(negedge clock);
        arst_n = 1'b1;

        do_request(OP_READ, 32'h42, '0, '0);
        wait_idle();
        end_test("first read miss");
        do_request(OP_WRITE, 32'h40, 32'hDEAD_BEEF, 4'b0101);
        do_request(OP_READ, 32'h40, '0, '0);
        wait_idle();
        end_test("partial write hit");
        do_request(OP_READ, 32'h80, '0, '0);
        wait_idle();
        end_test("dirty eviction");
        do_request(OP_WRITE, 32'h84, 32'h1234_5678, 4'b1100);
        do_request(OP_FLUSH, 32'h84, '0, '0);
        do_request(OP_READ, 32'h84, '0, '0);
        do_request(OP_FLUSH, 32'h84, '0, '0);
        wait_idle();
        end_test("flush dirty and clean");
        do_request(OP_READ, 32'h88, '0, '0);
        do_request(OP_READ, 32'h8C, '0, '0);
        wait_idle();
        prev_cycle = 0;
        for (int k = 0; k < 5; k++) begin
            do_request(OP_READ, burst[k], '0, '0);
            if (k > 0) begin
                check(accept_cycle - prev_cycle, 32'd1, "back-to-back acceptance");
            end
            prev_cycle = accept_cycle;
        end
        wait_idle();
        end_test("back-to-back read hits");
        // small range so that tags collide at each index
        for (int n = 0; n < 200; n++) begin
            drv_seed  = lcg_next(drv_seed);
            rand_addr = 32'h0000_1000;
            rand_addr[1:0] = drv_seed[25:24];
            rand_addr[2 +: 3] = drv_seed[18:16];
            rand_addr[2 + INDEX_BITS +: 2] = drv_seed[20:19];
            op = (drv_seed[23:21] < 3'd4) ? OP_READ :
                 (drv_seed[23:21] < 3'd7) ? OP_WRITE : OP_FLUSH;
            drv_seed = lcg_next(drv_seed);
            do_request(op, rand_addr, drv_seed, drv_seed[19:16]);
        end
        wait_idle();
        end_test("random traffic");

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/cache_pkg.sv
verilog/cache_array_if.sv
verilog/cache_arrays.sv
verilog/cache_controller.sv
verilog/l1_cache.sv
tb/l1_cache_checker.sv
tb/l1_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -Wno-fatal --top-module l1_cache_tb \
    -f sources.f -o l1_cache_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/l1_cache_sim > sim.log 2>&1 \
    || echo "Verification failed" >> sim.log
cat sim.log
grep -q "Verification failed" sim.log && exit 1 || exit 0
